// File: gs_butterfly.sv
module gs_butterfly (
  input  logic             clk,
  input  logic             rst,
  input  ntt_pkg::bf_in_t  in,
  output ntt_pkg::bf_out_t out
);

  localparam int PROD_W = 2 * ntt_pkg::COEF_W;

  typedef struct packed {
    logic                valid;
    ntt_pkg::coef_addr_t addr_lo;
    ntt_pkg::coef_addr_t addr_hi;
    ntt_pkg::coef_t      sum;
    logic [PROD_W-1:0]   prod;
  } bf_prod_t;

  logic [ntt_pkg::COEF_W:0] sum_raw;
  ntt_pkg::coef_t           sum_mod, diff_mod;
  ntt_pkg::bf_in_t          s1;
  bf_prod_t                 s2;

  // Operands are already reduced, so one conditional correction suffices
  always_comb begin
    sum_raw = {1'b0, in.a} + {1'b0, in.b};
    if (sum_raw >= ntt_pkg::NTT_Q) sum_mod = ntt_pkg::coef_t'(sum_raw - ntt_pkg::NTT_Q);
    else sum_mod = sum_raw[ntt_pkg::COEF_W-1:0];
    if (in.b >= in.a) diff_mod = in.b - in.a;
    else diff_mod = ntt_pkg::coef_t'(in.b + ntt_pkg::NTT_Q - in.a);
  end

  always_ff @(posedge clk) begin
    // Stage 1 keeps the sum in a and the difference in b
    s1.addr_lo <= in.addr_lo;
    s1.addr_hi <= in.addr_hi;
    s1.a       <= sum_mod;
    s1.b       <= diff_mod;
    s1.zeta    <= in.zeta;
    // Stage 2 twists the difference
    s2.addr_lo <= s1.addr_lo;
    s2.addr_hi <= s1.addr_hi;
    s2.sum     <= s1.a;
    s2.prod    <= s1.b * s1.zeta;
    // Stage 3 brings the product back below q
    out.addr_lo <= s2.addr_lo;
    out.addr_hi <= s2.addr_hi;
    out.a       <= s2.sum;
    out.b       <= ntt_pkg::coef_t'(s2.prod % ntt_pkg::NTT_Q);
    if (rst) begin
      s1.valid  <= 1'b0;
      s2.valid  <= 1'b0;
      out.valid <= 1'b0;
    end else begin
      s1.valid  <= in.valid;
      s2.valid  <= s1.valid;
      out.valid <= s2.valid;
    end
  end

  // A flush anywhere in the last three cycles empties the pipe, so skip those
  a_latency: assert property (
    @(posedge clk) disable iff (rst)
    (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)) |->
      (out.valid == $past(in.valid, ntt_pkg::BF_LATENCY))
  );

endmodule

// File: ntt_coef_mem.sv
module ntt_coef_mem (
  input  logic               clk,
  input  logic               rst,
  input  logic               zeroize,
  input  logic               load_en,
  input  ntt_pkg::coef_addr_t load_addr,
  input  ntt_pkg::coef_t     load_data,
  input  ntt_pkg::coef_addr_t rd_addr,
  output ntt_pkg::coef_t     rd_data,
  input  ntt_pkg::bf_op_t    op,
  output ntt_pkg::coef_t     a_out,
  output ntt_pkg::coef_t     b_out,
  input  logic               wr_en,
  input  ntt_pkg::coef_addr_t wr_addr_lo,
  input  ntt_pkg::coef_addr_t wr_addr_hi,
  input  ntt_pkg::coef_t     wr_a,
  input  ntt_pkg::coef_t     wr_b
);

  ntt_pkg::coef_t mem [ntt_pkg::NTT_N];

  // Host port and both butterfly operands read without a clock
  assign rd_data = mem[rd_addr];
  assign a_out   = mem[op.addr_lo];
  assign b_out   = mem[op.addr_hi];

  always_ff @(posedge clk) begin
    if (zeroize) begin
      for (int i = 0; i < ntt_pkg::NTT_N; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr_lo] <= wr_a;
      mem[wr_addr_hi] <= wr_b;
    end else if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // Both halves of a butterfly must land on different words
  a_wr_pair_distinct: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> (wr_addr_lo != wr_addr_hi)
  );

endmodule

// File: ntt_gs_top.f
ntt_pkg.sv
ntt_coef_mem.sv
ntt_twiddle_rom.sv
ntt_rd_ctrl.sv
gs_butterfly.sv
ntt_wr_ctrl.sv
ntt_gs_top.sv
tb_ntt_gs_top.sv

// File: ntt_gs_top.sv
module ntt_gs_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                zeroize,
  input  logic                start,
  input  logic                load_en,
  input  ntt_pkg::coef_addr_t load_addr,
  input  ntt_pkg::coef_t      load_data,
  input  ntt_pkg::coef_addr_t rd_addr,
  output ntt_pkg::coef_t      rd_data,
  output logic                busy,
  output logic                done
);

  ntt_pkg::bf_op_t     op;
  ntt_pkg::bf_in_t     bf_in;
  ntt_pkg::bf_out_t    bf_out;
  ntt_pkg::coef_t      a_rd, b_rd, zeta;
  ntt_pkg::coef_addr_t wr_addr_lo, wr_addr_hi;
  ntt_pkg::coef_t      wr_a, wr_b;
  logic                wr_en, round_drained, host_load_en, flush;

  // Zeroize also empties everything in flight so nothing lands after the clear
  assign flush        = rst || zeroize;
  assign host_load_en = load_en && !busy;

  ntt_rd_ctrl u_rd_ctrl (
    .clk(clk), .rst(rst), .zeroize(zeroize), .start(start),
    .round_drained(round_drained), .op(op), .busy(busy), .done(done), .round()
  );

  ntt_coef_mem u_coef_mem (
    .clk(clk), .rst(rst), .zeroize(zeroize),
    .load_en(host_load_en), .load_addr(load_addr), .load_data(load_data),
    .rd_addr(rd_addr), .rd_data(rd_data), .op(op), .a_out(a_rd), .b_out(b_rd),
    .wr_en(wr_en), .wr_addr_lo(wr_addr_lo), .wr_addr_hi(wr_addr_hi),
    .wr_a(wr_a), .wr_b(wr_b)
  );

  ntt_twiddle_rom u_twiddle_rom (.tw_idx(op.tw_idx), .zeta(zeta));

  // Read stage register
  always_ff @(posedge clk) begin
    bf_in.addr_lo <= op.addr_lo;
    bf_in.addr_hi <= op.addr_hi;
    bf_in.a       <= a_rd;
    bf_in.b       <= b_rd;
    bf_in.zeta    <= zeta;
    if (flush) bf_in.valid <= 1'b0;
    else bf_in.valid <= op.valid;
  end

  gs_butterfly u_butterfly (.clk(clk), .rst(flush), .in(bf_in), .out(bf_out));

  ntt_wr_ctrl u_wr_ctrl (
    .clk(clk), .rst(rst), .zeroize(zeroize), .res(bf_out),
    .wr_en(wr_en), .wr_addr_lo(wr_addr_lo), .wr_addr_hi(wr_addr_hi),
    .wr_a(wr_a), .wr_b(wr_b), .round_drained(round_drained)
  );

  // Butterflies in flight within a layer never share a coefficient
  a_no_rw_overlap: assert property (
    @(posedge clk) disable iff (flush)
    (busy && op.valid && wr_en) |->
      (op.addr_lo != wr_addr_lo) && (op.addr_lo != wr_addr_hi) &&
      (op.addr_hi != wr_addr_lo) && (op.addr_hi != wr_addr_hi)
  );

endmodule

// File: ntt_pkg.sv
package ntt_pkg;

  // Field widths
  localparam int COEF_W  = 12;
  localparam int ADDR_W  = 8;
  localparam int TW_W    = 7;
  localparam int ROUND_W = 3;

  // Ring parameters of the ML-KEM polynomial
  localparam int NTT_Q      = 3329;
  localparam int NTT_N      = 256;
  localparam int NTT_ZETA   = 17;
  localparam int NTT_ROUNDS = 7;

  // One butterfly per cycle, half the coefficients per layer
  localparam int BF_PER_ROUND = 128;

  // Register stages inside the GS butterfly
  localparam int BF_LATENCY = 3;

  typedef logic [COEF_W-1:0]  coef_t;
  typedef logic [ADDR_W-1:0]  coef_addr_t;
  typedef logic [TW_W-1:0]    twiddle_idx_t;
  typedef logic [ROUND_W-1:0] round_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_EXEC,
    EXEC_WAIT
  } ntt_read_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_MEM,
    WR_STAGE
  } ntt_write_state_t;

  // Butterfly issued by the read controller
  typedef struct packed {
    logic         valid;
    coef_addr_t   addr_lo;
    coef_addr_t   addr_hi;
    twiddle_idx_t tw_idx;
  } bf_op_t;

  // Operands after the read stage register
  typedef struct packed {
    logic       valid;
    coef_addr_t addr_lo;
    coef_addr_t addr_hi;
    coef_t      a;
    coef_t      b;
    coef_t      zeta;
  } bf_in_t;

  // Results headed for write-back
  typedef struct packed {
    logic       valid;
    coef_addr_t addr_lo;
    coef_addr_t addr_hi;
    coef_t      a;
    coef_t      b;
  } bf_out_t;

endpackage

// File: ntt_rd_ctrl.sv
module ntt_rd_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             zeroize,
  input  logic             start,
  input  logic             round_drained,
  output ntt_pkg::bf_op_t  op,
  output logic             busy,
  output logic             done,
  output ntt_pkg::round_t  round
);

  localparam int BF_W = $clog2(ntt_pkg::BF_PER_ROUND);
  localparam logic [BF_W-1:0] LAST_BF = BF_W'(ntt_pkg::BF_PER_ROUND - 1);
  localparam ntt_pkg::round_t LAST_ROUND = ntt_pkg::round_t'(ntt_pkg::NTT_ROUNDS - 1);

  ntt_pkg::ntt_read_state_t state, state_n;
  ntt_pkg::round_t          round_n;
  logic [BF_W-1:0]          bf_cnt, bf_cnt_n;
  logic                     done_n;
  ntt_pkg::coef_addr_t      j_ext, len_n, lo_n, len;
  ntt_pkg::twiddle_idx_t    tw_base;
  ntt_pkg::bf_op_t          op_n;

  always_comb begin
    state_n  = state;
    round_n  = round;
    bf_cnt_n = bf_cnt;
    case (state)
      ntt_pkg::RD_IDLE: begin
        if (start) begin
          state_n  = ntt_pkg::RD_EXEC;
          round_n  = '0;
          bf_cnt_n = '0;
        end
      end
      ntt_pkg::RD_EXEC: begin
        bf_cnt_n = bf_cnt + 1'b1;
        if (bf_cnt == LAST_BF) state_n = ntt_pkg::EXEC_WAIT;
      end
      ntt_pkg::EXEC_WAIT: begin
        // Next layer only reads once every result of this one is back in memory
        if (round_drained) begin
          if (round == LAST_ROUND) begin
            state_n = ntt_pkg::RD_IDLE;
          end else begin
            state_n  = ntt_pkg::RD_EXEC;
            round_n  = round + 1'b1;
            bf_cnt_n = '0;
          end
        end
      end
      default: state_n = ntt_pkg::RD_IDLE;
    endcase
    if (zeroize) state_n = ntt_pkg::RD_IDLE;
  end

  assign done_n = (state == ntt_pkg::EXEC_WAIT) && round_drained &&
                  (round == LAST_ROUND) && !zeroize;

  // Butterfly j takes the j-th index with the len bit clear as its low address
  always_comb begin
    j_ext   = ntt_pkg::coef_addr_t'(bf_cnt_n);
    len_n   = ntt_pkg::coef_addr_t'(2) << round_n;
    lo_n    = ((j_ext >> (int'(round_n) + 1)) << (int'(round_n) + 2)) | (j_ext & (len_n - 1'b1));
    tw_base = ntt_pkg::twiddle_idx_t'(ntt_pkg::BF_PER_ROUND - 1) -
              ((ntt_pkg::twiddle_idx_t'(1) << (LAST_ROUND - round_n)) - 1'b1);
    op_n.valid   = (state_n == ntt_pkg::RD_EXEC);
    op_n.addr_lo = lo_n;
    op_n.addr_hi = lo_n + len_n;
    op_n.tw_idx  = tw_base - ntt_pkg::twiddle_idx_t'(lo_n >> (int'(round_n) + 2));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ntt_pkg::RD_IDLE;
      round  <= '0;
      bf_cnt <= '0;
      op     <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
    end else begin
      state  <= state_n;
      round  <= round_n;
      bf_cnt <= bf_cnt_n;
      op     <= op_n;
      busy   <= (state_n != ntt_pkg::RD_IDLE);
      done   <= done_n;
    end
  end

  assign len = ntt_pkg::coef_addr_t'(2) << round;

  a_valid_in_exec: assert property (
    @(posedge clk) disable iff (rst) op.valid == (state == ntt_pkg::RD_EXEC));

  a_busy_state: assert property (
    @(posedge clk) disable iff (rst) busy == (state != ntt_pkg::RD_IDLE));

  a_pair_distance: assert property (
    @(posedge clk) disable iff (rst) op.valid |-> ((op.addr_hi - op.addr_lo) == len));

endmodule

// File: ntt_twiddle_rom.sv
module ntt_twiddle_rom (
  input  ntt_pkg::twiddle_idx_t tw_idx,
  output ntt_pkg::coef_t        zeta
);

  localparam int TW_DEPTH = 1 << ntt_pkg::TW_W;

  typedef logic [TW_DEPTH-1:0][ntt_pkg::COEF_W-1:0] table_t;

  function automatic int unsigned bitrev(int unsigned i);
    int unsigned r;
    r = 0;
    for (int b = 0; b < ntt_pkg::TW_W; b++) begin
      r[b] = i[ntt_pkg::TW_W-1-b];
    end
    return r;
  endfunction

  // Square and multiply keeps the elaboration loop short
  function automatic int unsigned pow_mod(int unsigned base, int unsigned e);
    int unsigned acc;
    int unsigned sq;
    acc = 1;
    sq  = base;
    for (int k = 0; k < ntt_pkg::TW_W; k++) begin
      if (e[k]) acc = (acc * sq) % ntt_pkg::NTT_Q;
      sq = (sq * sq) % ntt_pkg::NTT_Q;
    end
    return acc;
  endfunction

  function automatic table_t build_table();
    table_t t;
    for (int i = 0; i < TW_DEPTH; i++) begin
      t[i] = ntt_pkg::COEF_W'(pow_mod(ntt_pkg::NTT_ZETA, bitrev(i)));
    end
    return t;
  endfunction

  localparam table_t TW_TABLE = build_table();

  assign zeta = TW_TABLE[tw_idx];

endmodule

// File: ntt_wr_ctrl.sv
module ntt_wr_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                zeroize,
  input  ntt_pkg::bf_out_t    res,
  output logic                wr_en,
  output ntt_pkg::coef_addr_t wr_addr_lo,
  output ntt_pkg::coef_addr_t wr_addr_hi,
  output ntt_pkg::coef_t      wr_a,
  output ntt_pkg::coef_t      wr_b,
  output logic                round_drained
);

  localparam int BF_W = $clog2(ntt_pkg::BF_PER_ROUND);
  localparam logic [BF_W-1:0] LAST_BF = BF_W'(ntt_pkg::BF_PER_ROUND - 1);

  ntt_pkg::ntt_write_state_t state;
  logic [BF_W-1:0]           wr_cnt;

  // Results go straight to memory, both halves in the same cycle
  assign wr_en      = res.valid;
  assign wr_addr_lo = res.addr_lo;
  assign wr_addr_hi = res.addr_hi;
  assign wr_a       = res.a;
  assign wr_b       = res.b;

  // The last write of a layer is the count wrapping back to zero
  assign round_drained = res.valid && (wr_cnt == LAST_BF);

  always_ff @(posedge clk) begin
    if (rst || zeroize) begin
      state  <= ntt_pkg::WR_IDLE;
      wr_cnt <= '0;
    end else begin
      if (res.valid) wr_cnt <= wr_cnt + 1'b1;
      case (state)
        ntt_pkg::WR_IDLE: begin
          if (res.valid) state <= ntt_pkg::WR_MEM;
        end
        ntt_pkg::WR_MEM: begin
          // Move on one write early so the final write happens in WR_STAGE
          if (res.valid && (wr_cnt == LAST_BF - 1'b1)) state <= ntt_pkg::WR_STAGE;
        end
        ntt_pkg::WR_STAGE: begin
          state <= ntt_pkg::WR_IDLE;
        end
        default: state <= ntt_pkg::WR_IDLE;
      endcase
    end
  end

  a_wr_follows_valid: assert property (
    @(posedge clk) disable iff (rst || zeroize) wr_en == res.valid);

  a_drain_in_stage: assert property (
    @(posedge clk) disable iff (rst || zeroize)
    round_drained |-> (state == ntt_pkg::WR_STAGE)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ntt_gs_top -f ntt_gs_top.f

output=$(./obj_dir/Vtb_ntt_gs_top 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Verification passed'; then
  exit 0
fi
exit 1

// File: tb_ntt_gs_top.sv
module tb_ntt_gs_top;

  localparam int CLK_PERIOD    = 20;
  localparam int RUN_CYCLES    = ntt_pkg::NTT_ROUNDS *
                                 (ntt_pkg::BF_PER_ROUND + ntt_pkg::BF_LATENCY + 3);
  localparam int TEST_CYCLES   = 2 * ntt_pkg::NTT_N + RUN_CYCLES;
  localparam int NUM_TESTS     = 7;
  localparam int WATCHDOG_TIME = 5 * NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
  localparam int RUN_LIMIT     = 2 * RUN_CYCLES;

  logic                clk;
  logic                rst;
  logic                zeroize;
  logic                start;
  logic                load_en;
  ntt_pkg::coef_addr_t load_addr;
  ntt_pkg::coef_t      load_data;
  ntt_pkg::coef_addr_t rd_addr;
  ntt_pkg::coef_t      rd_data;
  logic                busy;
  logic                done;

  // Expected coefficients, kept in step with what the DUT should hold
  int model [ntt_pkg::NTT_N];

  ntt_gs_top dut0 (
    .clk(clk), .rst(rst), .zeroize(zeroize), .start(start),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .rd_addr(rd_addr), .rd_data(rd_data), .busy(busy), .done(done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s got %0d, expected %0d", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  // Zeta for table index k is 17 raised to the 7-bit reversal of k
  function automatic int zeta_of(input int k);
    int e;
    int acc;
    e = 0;
    for (int b = 0; b < 7; b++) begin
      if (k & (1 << b)) e = e | (1 << (6 - b));
    end
    acc = 1;
    for (int i = 0; i < e; i++) acc = (acc * ntt_pkg::NTT_ZETA) % ntt_pkg::NTT_Q;
    return acc;
  endfunction

  // GS layers with len 2 up to 128, block twiddles counting down per layer
  function automatic void intt_model();
    int len;
    int k;
    int z;
    int t;
    int u;
    for (int r = 0; r < ntt_pkg::NTT_ROUNDS; r++) begin
      len = 2 << r;
      for (int blk = 0; blk < ntt_pkg::NTT_N / (2 * len); blk++) begin
        k = 127 - ((1 << (6 - r)) - 1) - blk;
        z = zeta_of(k);
        for (int j = blk * 2 * len; j < blk * 2 * len + len; j++) begin
          t = model[j];
          u = model[j + len];
          model[j]       = (t + u) % ntt_pkg::NTT_Q;
          model[j + len] = (z * ((u - t + ntt_pkg::NTT_Q) % ntt_pkg::NTT_Q)) % ntt_pkg::NTT_Q;
        end
      end
    end
  endfunction

  task automatic load_random();
    int value;
    for (int i = 0; i < ntt_pkg::NTT_N; i++) begin
      value     = int'($urandom % ntt_pkg::NTT_Q);
      model[i]  = value;
      load_en   = 1'b1;
      load_addr = ntt_pkg::coef_addr_t'(i);
      load_data = ntt_pkg::coef_t'(value);
      next_cycle();
    end
    load_en = 1'b0;
  endtask

  task automatic compare_all();
    for (int i = 0; i < ntt_pkg::NTT_N; i++) begin
      rd_addr = ntt_pkg::coef_addr_t'(i);
      next_cycle();
      check_value(rd_data, model[i], $sformatf("coef[%0d]", i));
    end
  endtask

  // Pulses start, then follows busy and done cycle by cycle until done arrives
  task automatic run_intt(input bit noisy);
    int  cycles;
    bit  seen_done;
    start = 1'b1;
    next_cycle();
    start     = 1'b0;
    cycles    = 0;
    seen_done = 1'b0;
    while (!seen_done) begin
      if (done === 1'b1) begin
        seen_done = 1'b1;
        load_en   = 1'b0;
        start     = 1'b0;
        check_value(busy, 0, "busy in the done cycle");
      end else begin
        check_value(busy, 1, "busy during the run");
        if (noisy) begin
          load_en   = (($urandom % 4) == 0);
          load_addr = ntt_pkg::coef_addr_t'($urandom);
          load_data = ntt_pkg::coef_t'($urandom % ntt_pkg::NTT_Q);
          start     = (($urandom % 16) == 0);
        end
        cycles++;
        if (cycles > RUN_LIMIT) begin
          $display("The done pulse did not arrive within %0d cycles of start", RUN_LIMIT);
          $display("Verification failed");
          $fatal(1, "Run aborted");
        end
        next_cycle();
      end
    end
    next_cycle();
    check_value(done, 0, "done one cycle after its pulse");
    check_value(busy, 0, "busy after done");
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int wait_cycles;
    void'($urandom(84416));
    clk       = 1'b0;
    rst       = 1'b1;
    // Clear the coefficient store together with reset
    zeroize   = 1'b1;
    start     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    rd_addr   = '0;
    repeat (4) @(posedge clk);
    #2;
    rst     = 1'b0;
    zeroize = 1'b0;

    check_value(busy, 0, "busy after reset");
    check_value(done, 0, "done after reset");
    for (int i = 0; i < 8; i++) begin
      rd_addr = ntt_pkg::coef_addr_t'($urandom);
      next_cycle();
      check_value(rd_data, 0, $sformatf("coef[%0d] after reset", rd_addr));
    end

    for (int v = 0; v < 3; v++) begin
      load_random();
      intt_model();
      run_intt(1'b0);
      compare_all();
    end

    // Host loads and extra starts while busy must leave no trace
    load_random();
    intt_model();
    run_intt(1'b1);
    compare_all();

    load_random();
    start = 1'b1;
    next_cycle();
    start       = 1'b0;
    wait_cycles = 50 + int'($urandom % 700);
    repeat (wait_cycles) next_cycle();
    zeroize = 1'b1;
    next_cycle();
    zeroize = 1'b0;
    check_value(busy, 0, "busy after zeroize");
    for (int i = 0; i < ntt_pkg::BF_PER_ROUND; i++) begin
      check_value(done, 0, "done after zeroize");
      next_cycle();
    end
    for (int i = 0; i < ntt_pkg::NTT_N; i++) model[i] = 0;
    compare_all();

    load_random();
    intt_model();
    run_intt(1'b0);
    compare_all();

    $display("Verification passed");
    $finish;
  end

endmodule
